// File: filelist.f
verilog/hessian_fmt_pkg.sv
verilog/hessian_scale_pkg.sv
verilog/second_deriv_box.sv
verilog/mixed_deriv_box.sv
verilog/det_approx.sv
verilog/hessian_scale.sv
verilog/hessian_two_scales.sv
dv/hessian_two_scales_tb.sv

// File: Bender.yml
package:
  name: hessian_two_scales

sources:
  # packages first, then the RTL bottom-up
  - files:
      - verilog/hessian_fmt_pkg.sv
      - verilog/hessian_scale_pkg.sv
      - verilog/second_deriv_box.sv
      - verilog/mixed_deriv_box.sv
      - verilog/det_approx.sv
      - verilog/hessian_scale.sv
      - verilog/hessian_two_scales.sv

  # testbench
  - target: test
    files:
      - dv/hessian_two_scales_tb.sv

// File: dv/hessian_two_scales_tb.sv
`default_nettype none

module hessian_two_scales_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LATENCY = hessian_scale_pkg::VALID_LATENCY;
  localparam int RESET_LIMIT = 10;
  localparam int DRAIN_LIMIT = 20;

  // stimulus kinds, stored in bits 3:1 of a table entry, valid in bit 0
  localparam logic [2:0] K_ZERO = 3'd0;
  localparam logic [2:0] K_SMALL = 3'd1;
  localparam logic [2:0] K_SAT_POS = 3'd2;
  localparam logic [2:0] K_SAT_NEG = 3'd3;
  localparam logic [2:0] K_RAND = 3'd4;
  localparam logic [2:0] K_RAND_SAME = 3'd5;
  localparam int NUM_VEC = 22;
  localparam logic [3:0] VECTORS [NUM_VEC] = '{
    {K_ZERO, 1'b1}, {K_ZERO, 1'b0}, {K_SMALL, 1'b1}, {K_SMALL, 1'b0}, {K_SAT_POS, 1'b1},
    {K_SAT_NEG, 1'b1}, {K_RAND, 1'b1}, {K_RAND, 1'b1}, {K_RAND, 1'b1}, {K_RAND, 1'b1},
    {K_RAND, 1'b1}, {K_RAND, 1'b1}, {K_RAND, 1'b1}, {K_RAND, 1'b1}, {K_RAND_SAME, 1'b1},
    {K_RAND_SAME, 1'b0}, {K_RAND, 1'b0}, {K_SAT_NEG, 1'b1}, {K_SAT_POS, 1'b0},
    {K_SMALL, 1'b1}, {K_RAND_SAME, 1'b1}, {K_ZERO, 1'b1}
  };

  // grid positions of the per-scale and the shared Dxy corners
  localparam int OWN_POS [12] = '{0, 1, 2, 3, 4, 7, 8, 11, 12, 13, 14, 15};
  localparam int SHARED_POS [4] = '{5, 6, 9, 10};

  typedef struct packed {
    logic valid;
    logic chk_data;
    hessian_fmt_pkg::det_t d09;
    hessian_fmt_pkg::det_t d15;
  } expect_t;

  logic clk;
  logic i_rst_n;
  logic din_valid;
  hessian_fmt_pkg::corner_t dxy_shared [4];
  hessian_fmt_pkg::corner_t dxx_09 [8];
  hessian_fmt_pkg::corner_t dyy_09 [8];
  hessian_fmt_pkg::corner_t dxy_09 [12];
  hessian_fmt_pkg::corner_t dxx_15 [8];
  hessian_fmt_pkg::corner_t dyy_15 [8];
  hessian_fmt_pkg::corner_t dxy_15 [12];
  logic d_valid;
  hessian_fmt_pkg::det_t d_09;
  hessian_fmt_pkg::det_t d_15;

  logic [31:0] seed;
  expect_t exp_q [$];

  hessian_two_scales uut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_din_valid  (din_valid),
    .i_dxy_shared (dxy_shared),
    .i_dxx_09     (dxx_09),
    .i_dyy_09     (dyy_09),
    .i_dxy_09     (dxy_09),
    .i_dxx_15     (dxx_15),
    .i_dyy_15     (dyy_15),
    .i_dxy_15     (dxy_15),
    .o_d_valid    (d_valid),
    .o_d_09       (d_09),
    .o_d_15       (d_15)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic hessian_fmt_pkg::corner_t rand_corner();
    logic [31:0] r;
    r = lcg_next();
    return r[31:4];
  endfunction

  function automatic longint rect(input longint p00, p01, p10, p11);
    return p00 - p01 - p10 + p11;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // reference model of one scale
  ////////////////////////////////////////////////////////////////////

  function automatic hessian_fmt_pkg::det_t ref_det(input bit scale_15);
    hessian_fmt_pkg::corner_t xx [8];
    hessian_fmt_pkg::corner_t yy [8];
    hessian_fmt_pkg::corner_t g [16];
    longint dxx, dyy, dxy, ca, cb;
    logic signed [127:0] wide;
    logic signed [127:0] term_b;
    logic signed [127:0] sat_max;
    for (int i = 0; i < 8; i++) begin
      xx[i] = scale_15 ? dxx_15[i] : dxx_09[i];
      yy[i] = scale_15 ? dyy_15[i] : dyy_09[i];
    end
    for (int i = 0; i < 12; i++) g[OWN_POS[i]] = scale_15 ? dxy_15[i] : dxy_09[i];
    for (int i = 0; i < 4; i++) g[SHARED_POS[i]] = dxy_shared[i];
    ca = scale_15 ? hessian_scale_pkg::CONST_A_15 : hessian_scale_pkg::CONST_A_09;
    cb = scale_15 ? hessian_scale_pkg::CONST_B_15 : hessian_scale_pkg::CONST_B_09;
    dxx = rect(xx[0], xx[1], xx[2], xx[3]) - 3 * rect(xx[4], xx[5], xx[6], xx[7]);
    dyy = rect(yy[0], yy[1], yy[2], yy[3]) - 3 * rect(yy[4], yy[5], yy[6], yy[7]);
    dxy = rect(g[0], g[1], g[4], g[5]) + rect(g[10], g[11], g[14], g[15])
        - rect(g[2], g[3], g[6], g[7]) - rect(g[8], g[9], g[12], g[13]);
    wide = dxx;
    wide = wide * dyy * ca;
    term_b = dxy;
    term_b = term_b * dxy * cb;
    wide = (wide - term_b) >>> hessian_scale_pkg::DET_SHIFT;
    sat_max = (128'sd1 <<< (hessian_fmt_pkg::DET_WIDTH - 1)) - 1;
    if (wide > sat_max) return sat_max[hessian_fmt_pkg::DET_WIDTH-1:0];
    if (wide < -sat_max - 1) return {1'b1, {(hessian_fmt_pkg::DET_WIDTH-1){1'b0}}};
    return wide[hessian_fmt_pkg::DET_WIDTH-1:0];
  endfunction

  task automatic fill_corners(input logic [2:0] kind);
    hessian_fmt_pkg::corner_t m;
    m = '1;
    for (int i = 0; i < 4; i++) dxy_shared[i] = '0;
    for (int i = 0; i < 8; i++) begin
      dxx_09[i] = '0;
      dyy_09[i] = '0;
      dxx_15[i] = '0;
      dyy_15[i] = '0;
    end
    for (int i = 0; i < 12; i++) begin
      dxy_09[i] = '0;
      dxy_15[i] = '0;
    end
    case (kind)
      K_SMALL: begin
        // only Dxy non-zero; F shared, A at 9x9, C and P at 15x15
        dxy_shared[0] = 28'd20000;
        dxy_09[0] = 28'd3000;
        dxy_15[2] = 28'd1500;
        dxy_15[11] = 28'd7000;
      end
      K_SAT_POS: begin
        // outer box at +2max, inner lobe at -2max
        dxx_09[0] = m;
        dxx_09[3] = m;
        dxx_09[5] = m;
        dxx_09[6] = m;
        dyy_09 = dxx_09;
        dxx_15 = dxx_09;
        dyy_15 = dyy_09;
      end
      K_SAT_NEG: begin
        // A D M P plus all of F G J K, Dxy at 8 times max
        dxy_09[0] = m;
        dxy_09[3] = m;
        dxy_09[8] = m;
        dxy_09[11] = m;
        dxy_15 = dxy_09;
        for (int i = 0; i < 4; i++) dxy_shared[i] = m;
      end
      K_RAND, K_RAND_SAME: begin
        for (int i = 0; i < 4; i++) dxy_shared[i] = rand_corner();
        for (int i = 0; i < 8; i++) begin
          dxx_09[i] = rand_corner();
          dyy_09[i] = rand_corner();
          dxx_15[i] = rand_corner();
          dyy_15[i] = rand_corner();
        end
        for (int i = 0; i < 12; i++) begin
          dxy_09[i] = rand_corner();
          dxy_15[i] = rand_corner();
        end
        if (kind == K_RAND_SAME) begin
          dxx_15 = dxx_09;
          dyy_15 = dyy_09;
          dxy_15 = dxy_09;
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, want);
      $display("** FAIL **");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic check_output();
    expect_t e;
    e = exp_q.pop_front();
    check_value(d_valid, e.valid, "o_d_valid");
    if (e.chk_data) begin
      check_value(d_09, e.d09, "o_d_09");
      check_value(d_15, e.d15, "o_d_15");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    $display("** FAIL **");
    $fatal(1, "wait loop timed out");
  endtask

  initial begin
    int cycles;
    expect_t e;
    clk = 1'b0;
    i_rst_n = 1'b0;
    din_valid = 1'b0;
    seed = 32'h2b84_3feb;
    fill_corners(K_ZERO);
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    cycles = 0;
    while (d_valid !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_LIMIT) report_timeout("o_d_valid did not go low after reset");
    end
    // the first outputs after reset carry no data
    for (int i = 0; i < LATENCY; i++) begin
      e = '0;
      exp_q.push_back(e);
    end
    for (int v = 0; v < NUM_VEC; v++) begin
      if (exp_q.size() == LATENCY) check_output();
      fill_corners(VECTORS[v][3:1]);
      din_valid = VECTORS[v][0];
      e.valid = VECTORS[v][0];
      e.chk_data = 1'b1;
      e.d09 = ref_det(1'b0);
      e.d15 = ref_det(1'b1);
      exp_q.push_back(e);
      @(negedge clk);
    end
    din_valid = 1'b0;
    cycles = 0;
    while (exp_q.size() != 0) begin
      check_output();
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) report_timeout("pipeline did not drain");
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/hessian_two_scales.sv
`default_nettype none

module hessian_two_scales (
  input  wire                          clk,
  input  wire                          i_rst_n,
  input  wire                          i_din_valid,
  // F G J K, common to every scale
  input  wire hessian_fmt_pkg::corner_t i_dxy_shared [4],

  input  wire hessian_fmt_pkg::corner_t i_dxx_09 [8],
  input  wire hessian_fmt_pkg::corner_t i_dyy_09 [8],
  input  wire hessian_fmt_pkg::corner_t i_dxy_09 [12],

  input  wire hessian_fmt_pkg::corner_t i_dxx_15 [8],
  input  wire hessian_fmt_pkg::corner_t i_dyy_15 [8],
  input  wire hessian_fmt_pkg::corner_t i_dxy_15 [12],

  output logic                         o_d_valid,
  output wire hessian_fmt_pkg::det_t   o_d_09,
  output wire hessian_fmt_pkg::det_t   o_d_15
);

  //////////////////////////////////////////////////////////////////////
  // 9x9 scale, also the source of the output valid
  //////////////////////////////////////////////////////////////////////

  hessian_scale #(
    .CONST_A (hessian_scale_pkg::CONST_A_09),
    .CONST_B (hessian_scale_pkg::CONST_B_09)
  ) u_scale_09 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_din_valid  (i_din_valid),
    .i_dxx        (i_dxx_09),
    .i_dyy        (i_dyy_09),
    .i_dxy        (i_dxy_09),
    .i_dxy_shared (i_dxy_shared),
    .o_det_valid  (o_d_valid),
    .o_det        (o_d_09)
  );

  //////////////////////////////////////////////////////////////////////
  // 15x15 scale, valid identical to the 9x9 one
  //////////////////////////////////////////////////////////////////////

  hessian_scale #(
    .CONST_A (hessian_scale_pkg::CONST_A_15),
    .CONST_B (hessian_scale_pkg::CONST_B_15)
  ) u_scale_15 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_din_valid  (i_din_valid),
    .i_dxx        (i_dxx_15),
    .i_dyy        (i_dyy_15),
    .i_dxy        (i_dxy_15),
    .i_dxy_shared (i_dxy_shared),
    .o_det_valid  (),
    .o_det        (o_d_15)
  );

endmodule

`default_nettype wire

// File: verilog/hessian_scale.sv
`default_nettype none

// one filter scale: input register, three box responses, determinant
module hessian_scale #(
  parameter logic [hessian_scale_pkg::CONST_WIDTH-1:0] CONST_A = hessian_scale_pkg::CONST_A_09,
  parameter logic [hessian_scale_pkg::CONST_WIDTH-1:0] CONST_B = hessian_scale_pkg::CONST_B_09
) (
  input  wire                          clk,
  input  wire                          i_rst_n,
  input  wire                          i_din_valid,
  input  wire hessian_fmt_pkg::corner_t i_dxx [8],
  input  wire hessian_fmt_pkg::corner_t i_dyy [8],
  // A B C D E H I L M N O P
  input  wire hessian_fmt_pkg::corner_t i_dxy [12],
  // F G J K
  input  wire hessian_fmt_pkg::corner_t i_dxy_shared [4],
  output logic                         o_det_valid,
  output hessian_fmt_pkg::det_t        o_det
);

  hessian_fmt_pkg::corner_t dxx_q [8];
  hessian_fmt_pkg::corner_t dyy_q [8];
  hessian_fmt_pkg::corner_t dxy_q [12];
  hessian_fmt_pkg::corner_t shared_q [4];
  hessian_fmt_pkg::corner_t grid [16];
  hessian_fmt_pkg::resp_t   dxx_resp;
  hessian_fmt_pkg::resp_t   dyy_resp;
  hessian_fmt_pkg::resp_t   dxy_resp;
  logic [hessian_scale_pkg::VALID_LATENCY-1:0] valid_q;

  always_ff @(posedge clk) begin
    dxx_q    <= i_dxx;
    dyy_q    <= i_dyy;
    dxy_q    <= i_dxy;
    shared_q <= i_dxy_shared;
  end

  // row-major 4x4 grid, shared corners in the middle
  always_comb begin
    grid[0]  = dxy_q[0];
    grid[1]  = dxy_q[1];
    grid[2]  = dxy_q[2];
    grid[3]  = dxy_q[3];
    grid[4]  = dxy_q[4];
    grid[5]  = shared_q[0];
    grid[6]  = shared_q[1];
    grid[7]  = dxy_q[5];
    grid[8]  = dxy_q[6];
    grid[9]  = shared_q[2];
    grid[10] = shared_q[3];
    grid[11] = dxy_q[7];
    grid[12] = dxy_q[8];
    grid[13] = dxy_q[9];
    grid[14] = dxy_q[10];
    grid[15] = dxy_q[11];
  end

  second_deriv_box u_dxx (.clk(clk), .i_corner(dxx_q), .o_resp(dxx_resp));
  second_deriv_box u_dyy (.clk(clk), .i_corner(dyy_q), .o_resp(dyy_resp));
  mixed_deriv_box  u_dxy (.clk(clk), .i_corner(grid),  .o_resp(dxy_resp));

  det_approx #(.CONST_A(CONST_A), .CONST_B(CONST_B)) u_det (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_dxx   (dxx_resp),
    .i_dyy   (dyy_resp),
    .i_dxy   (dxy_resp),
    .o_det   (o_det)
  );

  // valid follows the data through all seven stages
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[hessian_scale_pkg::VALID_LATENCY-2:0], i_din_valid};
    end
  end

  assign o_det_valid = valid_q[hessian_scale_pkg::VALID_LATENCY-1];

  a_valid_latency: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    $past(i_rst_n, hessian_scale_pkg::VALID_LATENCY) |->
      o_det_valid == $past(i_din_valid, hessian_scale_pkg::VALID_LATENCY)
  );

  a_valid_known: assert property (
    @(posedge clk) disable iff (!i_rst_n) !$isunknown(o_det_valid)
  );

endmodule

`default_nettype wire

// File: verilog/det_approx.sv
`default_nettype none

// det = Dxx*Dyy*A - Dxy^2*B, then >>> DET_SHIFT and clamp
module det_approx #(
  parameter logic [hessian_scale_pkg::CONST_WIDTH-1:0] CONST_A = hessian_scale_pkg::CONST_A_09,
  parameter logic [hessian_scale_pkg::CONST_WIDTH-1:0] CONST_B = hessian_scale_pkg::CONST_B_09
) (
  input  wire                    clk,
  input  wire                    i_rst_n,
  input  wire hessian_fmt_pkg::resp_t i_dxx,
  input  wire hessian_fmt_pkg::resp_t i_dyy,
  input  wire hessian_fmt_pkg::resp_t i_dxy,
  output hessian_fmt_pkg::det_t  o_det
);

  // exact widths, no truncation before the final shift
  typedef logic signed [2*hessian_fmt_pkg::RESP_WIDTH-1:0] prod_t;
  typedef logic signed [2*hessian_fmt_pkg::RESP_WIDTH+hessian_scale_pkg::CONST_WIDTH:0] wgt_t;
  typedef logic signed [2*hessian_fmt_pkg::RESP_WIDTH+hessian_scale_pkg::CONST_WIDTH+1:0] diff_t;

  prod_t prod_xy_q;
  prod_t prod_dxy_q;
  wgt_t  wgt_a_q;
  wgt_t  wgt_b_q;
  diff_t diff_q;
  diff_t shifted;
  hessian_fmt_pkg::det_t det_sat;

  //////////////////////////////////////////////////////////////////////
  // stages 1 to 3
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    prod_xy_q  <= i_dxx * i_dyy;
    prod_dxy_q <= i_dxy * i_dxy;
    wgt_a_q    <= prod_xy_q * $signed({1'b0, CONST_A});
    wgt_b_q    <= prod_dxy_q * $signed({1'b0, CONST_B});
    diff_q     <= wgt_a_q - wgt_b_q;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 4, shift and saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    shifted = diff_q >>> hessian_scale_pkg::DET_SHIFT;
    // in range when all bits above the det sign match it
    if (&shifted[$bits(diff_t)-1:hessian_fmt_pkg::DET_WIDTH-1] ||
        ~|shifted[$bits(diff_t)-1:hessian_fmt_pkg::DET_WIDTH-1]) begin
      det_sat = shifted[hessian_fmt_pkg::DET_WIDTH-1:0];
    end else if (shifted[$bits(diff_t)-1]) begin
      det_sat = {1'b1, {(hessian_fmt_pkg::DET_WIDTH-1){1'b0}}};
    end else begin
      det_sat = {1'b0, {(hessian_fmt_pkg::DET_WIDTH-1){1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    o_det <= det_sat;
  end

  // the weight on Dxx*Dyy never falls below the Dxy weight
  if (CONST_A < CONST_B) begin : g_const_check
    $error("det_approx: CONST_A must not be below CONST_B");
  end

  // known responses give a known determinant after the four stages
  a_det_known: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    !$isunknown({i_dxx, i_dyy, i_dxy}) |-> ##4 !$isunknown(o_det)
  );

endmodule

`default_nettype wire

// File: verilog/mixed_deriv_box.sv
`default_nettype none

// Dxy box filter response over a row-major 4x4 corner grid
//   A B C D
//   E F G H
//   I J K L
//   M N O P
module mixed_deriv_box (
  input  wire                     clk,
  input  wire hessian_fmt_pkg::corner_t i_corner [16],
  output hessian_fmt_pkg::resp_t  o_resp
);

  hessian_fmt_pkg::resp_t lobe_tl;
  hessian_fmt_pkg::resp_t lobe_tr;
  hessian_fmt_pkg::resp_t lobe_bl;
  hessian_fmt_pkg::resp_t lobe_br;
  hessian_fmt_pkg::resp_t lobe_tl_q;
  hessian_fmt_pkg::resp_t lobe_tr_q;
  hessian_fmt_pkg::resp_t lobe_bl_q;
  hessian_fmt_pkg::resp_t lobe_br_q;

  always_comb begin
    // A B E F
    lobe_tl = hessian_fmt_pkg::resp_t'(i_corner[0]) - hessian_fmt_pkg::resp_t'(i_corner[1])
            - hessian_fmt_pkg::resp_t'(i_corner[4]) + hessian_fmt_pkg::resp_t'(i_corner[5]);
    // C D G H
    lobe_tr = hessian_fmt_pkg::resp_t'(i_corner[2]) - hessian_fmt_pkg::resp_t'(i_corner[3])
            - hessian_fmt_pkg::resp_t'(i_corner[6]) + hessian_fmt_pkg::resp_t'(i_corner[7]);
    // I J M N
    lobe_bl = hessian_fmt_pkg::resp_t'(i_corner[8]) - hessian_fmt_pkg::resp_t'(i_corner[9])
            - hessian_fmt_pkg::resp_t'(i_corner[12]) + hessian_fmt_pkg::resp_t'(i_corner[13]);
    // K L O P
    lobe_br = hessian_fmt_pkg::resp_t'(i_corner[10]) - hessian_fmt_pkg::resp_t'(i_corner[11])
            - hessian_fmt_pkg::resp_t'(i_corner[14]) + hessian_fmt_pkg::resp_t'(i_corner[15]);
  end

  // stage 1, lobe sums
  always_ff @(posedge clk) begin
    lobe_tl_q <= lobe_tl;
    lobe_tr_q <= lobe_tr;
    lobe_bl_q <= lobe_bl;
    lobe_br_q <= lobe_br;
  end

  // stage 2, diagonal minus anti-diagonal
  always_ff @(posedge clk) begin
    o_resp <= (lobe_tl_q + lobe_br_q) - (lobe_tr_q + lobe_bl_q);
  end

endmodule

`default_nettype wire

// File: verilog/second_deriv_box.sv
`default_nettype none

// Dxx or Dyy box filter response
// corners 0..3 span the outer box, 4..7 the inner lobe
module second_deriv_box (
  input  wire                     clk,
  input  wire hessian_fmt_pkg::corner_t i_corner [8],
  output hessian_fmt_pkg::resp_t  o_resp
);

  hessian_fmt_pkg::resp_t outer_sum;
  hessian_fmt_pkg::resp_t inner_sum;
  hessian_fmt_pkg::resp_t outer_q;
  hessian_fmt_pkg::resp_t inner_q;

  // rectangle sums, p00 - p01 - p10 + p11
  always_comb begin
    outer_sum = hessian_fmt_pkg::resp_t'(i_corner[0])
              - hessian_fmt_pkg::resp_t'(i_corner[1])
              - hessian_fmt_pkg::resp_t'(i_corner[2])
              + hessian_fmt_pkg::resp_t'(i_corner[3]);
    inner_sum = hessian_fmt_pkg::resp_t'(i_corner[4])
              - hessian_fmt_pkg::resp_t'(i_corner[5])
              - hessian_fmt_pkg::resp_t'(i_corner[6])
              + hessian_fmt_pkg::resp_t'(i_corner[7]);
  end

  // stage 1
  always_ff @(posedge clk) begin
    outer_q <= outer_sum;
    inner_q <= inner_sum;
  end

  // stage 2, inner lobe carries weight -3 on top of the outer box
  always_ff @(posedge clk) begin
    o_resp <= outer_q - (inner_q + (inner_q <<< 1));
  end

endmodule

`default_nettype wire

// File: verilog/hessian_scale_pkg.sv
`default_nettype none

package hessian_scale_pkg;

  //////////////////////////////////////////////////////////////////////
  // per-scale determinant weights
  //////////////////////////////////////////////////////////////////////

  localparam int CONST_WIDTH = 18;

  // 9x9 filter
  localparam logic [CONST_WIDTH-1:0] CONST_A_09 = 18'd81827;
  localparam logic [CONST_WIDTH-1:0] CONST_B_09 = 18'd66280;

  // 15x15 filter
  localparam logic [CONST_WIDTH-1:0] CONST_A_15 = 18'd10604;
  localparam logic [CONST_WIDTH-1:0] CONST_B_15 = 18'd8589;

  // arithmetic right shift ahead of saturation
  localparam int DET_SHIFT = 40;

  // input register + 2 box stages + 4 determinant stages
  localparam int VALID_LATENCY = 7;

endpackage

`default_nettype wire

// File: verilog/hessian_fmt_pkg.sv
`default_nettype none

package hessian_fmt_pkg;

  //////////////////////////////////////////////////////////////////////
  // integral-image sample and result widths
  //////////////////////////////////////////////////////////////////////

  // unsigned corner sample of the integral image
  localparam int DATA_WIDTH = 28;

  // signed box response, room for the 3x inner lobe and the sign
  localparam int RESP_WIDTH = DATA_WIDTH + 4;

  // signed determinant after shift and saturation
  localparam int DET_WIDTH  = DATA_WIDTH + 4;

  typedef logic [DATA_WIDTH-1:0] corner_t;

  typedef logic signed [RESP_WIDTH-1:0] resp_t;

  typedef logic signed [DET_WIDTH-1:0] det_t;

endpackage

`default_nettype wire
